//--- Makefile
# Verilator build, run and lint for the operand memory testbench
VERILATOR  ?= verilator
TOP        := tb_dp_mem
FILELIST   := src.f
VFLAGS     := --binary --assert -j 0
LINT_FLAGS := --lint-only -Wall
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- data_memory.sv
// One RAM plus an I/O port bank; read latency is 1 cycle and a same-cycle read of a written word returns old data
`timescale 1ns/10ps

module data_memory #(
    parameter int mem_depth = 256
) (
    input  logic                                      clock,
    input  logic                                      reset,

    // Read port
    input  logic                                      read_enable,
    input  dpm_map_pkg::mem_addr_t                    read_addr,
    input  logic                                      read_is_io,
    input  logic [dpm_io_pkg::io_port_addr_width-1:0] io_port_read,
    input  dpm_io_pkg::io_word_array_t                io_read_data,
    output dpm_map_pkg::word_t                        read_data,

    // Write port, already qualified by range and instruction status
    input  logic                                      write_enable,
    input  dpm_map_pkg::mem_addr_t                    write_addr,
    input  logic                                      write_is_io,
    input  dpm_map_pkg::word_t                        write_data,
    output dpm_io_pkg::io_sel_t                       io_wren,
    output dpm_io_pkg::io_word_array_t                io_write_data
);

    dpm_map_pkg::word_t                        ram [mem_depth];
    dpm_map_pkg::word_t                        ram_word;
    dpm_map_pkg::word_t                        io_word;
    logic                                      read_enable_q;
    logic                                      read_is_io_q;
    logic [dpm_io_pkg::io_port_addr_width-1:0] io_port_write;
    logic                                      ram_wren;
    logic                                      io_port_wren;

    // --------------------------------------------------
    // Write steering
    // I/O writes never reach the RAM

    assign io_port_write = write_addr[dpm_io_pkg::io_port_addr_width-1:0];
    assign ram_wren      = write_enable & ~write_is_io;
    assign io_port_wren  = write_enable & write_is_io;

    // --------------------------------------------------
    // RAM with registered read

    always_ff @(posedge clock) begin
        if (ram_wren) begin
            ram[write_addr] <= write_data;
        end
        ram_word <= ram[read_addr];
    end

    // Sample the addressed input port alongside the RAM read
    always_ff @(posedge clock) begin
        io_word <= io_read_data[io_port_read];
    end

    // Read mux controls, aligned with the registered data
    always_ff @(posedge clock) begin
        if (reset) begin
            read_enable_q <= 1'b0;
            read_is_io_q  <= 1'b0;
        end else begin
            read_enable_q <= read_enable;
            read_is_io_q  <= read_is_io;
        end
    end

    // --------------------------------------------------
    // Read mux

    always_comb begin
        if (!read_enable_q) begin
            read_data = '0;
        end else if (read_is_io_q) begin
            read_data = io_word;
        end else begin
            read_data = ram_word;
        end
    end

    // --------------------------------------------------
    // I/O write registers
    // io_wren is high for the one cycle after the commit edge

    always_ff @(posedge clock) begin
        if (reset) begin
            io_wren       <= '0;
            io_write_data <= '0;
        end else begin
            io_wren <= '0;
            if (io_port_wren) begin
                io_wren[io_port_write]       <= 1'b1;
                io_write_data[io_port_write] <= write_data;
            end
        end
    end

endmodule

//--- datapath_memory.sv
// Operand memories A and B; address 0 reads as zero, writes outside the range or I/O window are dropped
`timescale 1ns/10ps

module datapath_memory (
    input  logic                       clock,
    input  logic                       reset,

    // Status of the instruction issuing this cycle
    input  logic                       ior,
    input  logic                       cancel,

    input  dpm_map_pkg::addr_t         read_addr_a,
    input  dpm_map_pkg::addr_t         read_addr_b,
    input  dpm_map_pkg::addr_t         write_addr_a,
    input  dpm_map_pkg::addr_t         write_addr_b,
    input  logic                       read_is_io_a,
    input  logic                       read_is_io_b,
    input  logic                       write_is_io_a,
    input  logic                       write_is_io_b,

    // Late data from the ALU
    input  dpm_map_pkg::word_t         write_data_a,
    input  dpm_map_pkg::word_t         write_data_b,

    input  dpm_io_pkg::io_word_array_t io_read_data_a,
    input  dpm_io_pkg::io_word_array_t io_read_data_b,
    output dpm_io_pkg::io_word_array_t io_write_data_a,
    output dpm_io_pkg::io_word_array_t io_write_data_b,
    output dpm_io_pkg::io_sel_t        io_wren_a,
    output dpm_io_pkg::io_sel_t        io_wren_b,

    output dpm_map_pkg::word_t         read_data_a,
    output dpm_map_pkg::word_t         read_data_b
);

    // --------------------------------------------------
    // Depth is the smaller of the read and write ranges

    localparam int mem_a_read_depth  = dpm_map_pkg::mem_a_read_bound_addr
                                     - dpm_map_pkg::mem_a_read_base_addr + 1;
    localparam int mem_a_write_depth = dpm_map_pkg::mem_a_write_bound_addr
                                     - dpm_map_pkg::mem_a_write_base_addr + 1;
    localparam int mem_a_depth       = (mem_a_read_depth <= mem_a_write_depth) ?
                                       mem_a_read_depth : mem_a_write_depth;

    localparam int mem_b_read_depth  = dpm_map_pkg::mem_b_read_bound_addr
                                     - dpm_map_pkg::mem_b_read_base_addr + 1;
    localparam int mem_b_write_depth = dpm_map_pkg::mem_b_write_bound_addr
                                     - dpm_map_pkg::mem_b_write_base_addr + 1;
    localparam int mem_b_depth       = (mem_b_read_depth <= mem_b_write_depth) ?
                                       mem_b_read_depth : mem_b_write_depth;

    function automatic logic in_write_range(input dpm_map_pkg::addr_t addr,
                                            input int base,
                                            input int bound);
        return (int'(addr) >= base) && (int'(addr) <= bound);
    endfunction

    dpm_map_pkg::waddr_t write_a_retimed;
    dpm_map_pkg::waddr_t write_b_retimed;
    logic [1:0]          status_previous;
    logic                ior_previous;
    logic                cancel_previous;
    logic                commit_ok;
    logic                write_enable_a;
    logic                write_enable_b;

    // --------------------------------------------------
    // Retime write addresses and status to meet the data

    delay_line #(
        .depth     (dpm_map_pkg::write_retime_stages),
        .payload_t (dpm_map_pkg::waddr_t)
    ) write_a_dl_i (
        .clock    (clock),
        .reset    (reset),
        .in_data  ('{addr: write_addr_a, is_io: write_is_io_a}),
        .out_data (write_a_retimed)
    );

    delay_line #(
        .depth     (dpm_map_pkg::write_retime_stages),
        .payload_t (dpm_map_pkg::waddr_t)
    ) write_b_dl_i (
        .clock    (clock),
        .reset    (reset),
        .in_data  ('{addr: write_addr_b, is_io: write_is_io_b}),
        .out_data (write_b_retimed)
    );

    delay_line #(
        .depth     (dpm_map_pkg::write_retime_stages),
        .payload_t (logic [1:0])
    ) status_dl_i (
        .clock    (clock),
        .reset    (reset),
        .in_data  ({ior, cancel}),
        .out_data (status_previous)
    );

    assign {ior_previous, cancel_previous} = status_previous;

    // Only ready, uncancelled instructions commit
    assign commit_ok = ior_previous & ~cancel_previous;

    // I/O window is decoded apart from the RAM range
    assign write_enable_a = commit_ok
        & (write_a_retimed.is_io
           | in_write_range(write_a_retimed.addr, dpm_map_pkg::mem_a_write_base_addr,
                            dpm_map_pkg::mem_a_write_bound_addr));
    assign write_enable_b = commit_ok
        & (write_b_retimed.is_io
           | in_write_range(write_b_retimed.addr, dpm_map_pkg::mem_b_write_base_addr,
                            dpm_map_pkg::mem_b_write_bound_addr));

    // --------------------------------------------------
    // Memories, indexed by the low address bits

    data_memory #(
        .mem_depth (mem_a_depth)
    ) mem_a_i (
        .clock         (clock),
        .reset         (reset),
        .read_enable   (read_addr_a != '0),
        .read_addr     (read_addr_a[dpm_map_pkg::mem_addr_width-1:0]),
        .read_is_io    (read_is_io_a),
        .io_port_read  (read_addr_a[dpm_io_pkg::io_port_addr_width-1:0]),
        .io_read_data  (io_read_data_a),
        .read_data     (read_data_a),
        .write_enable  (write_enable_a),
        .write_addr    (write_a_retimed.addr[dpm_map_pkg::mem_addr_width-1:0]),
        .write_is_io   (write_a_retimed.is_io),
        .write_data    (write_data_a),
        .io_wren       (io_wren_a),
        .io_write_data (io_write_data_a)
    );

    data_memory #(
        .mem_depth (mem_b_depth)
    ) mem_b_i (
        .clock         (clock),
        .reset         (reset),
        .read_enable   (read_addr_b != '0),
        .read_addr     (read_addr_b[dpm_map_pkg::mem_addr_width-1:0]),
        .read_is_io    (read_is_io_b),
        .io_port_read  (read_addr_b[dpm_io_pkg::io_port_addr_width-1:0]),
        .io_read_data  (io_read_data_b),
        .read_data     (read_data_b),
        .write_enable  (write_enable_b),
        .write_addr    (write_b_retimed.addr[dpm_map_pkg::mem_addr_width-1:0]),
        .write_is_io   (write_b_retimed.is_io),
        .write_data    (write_data_b),
        .io_wren       (io_wren_b),
        .io_write_data (io_write_data_b)
    );

endmodule

//--- delay_line.sv
// Fixed-latency register chain; a depth of 0 is a plain wire and payload_t must be a packed type
`timescale 1ns/10ps

module delay_line #(
    parameter int  depth     = dpm_map_pkg::write_retime_stages,
    parameter type payload_t = dpm_map_pkg::waddr_t
) (
    input  logic     clock,
    input  logic     reset,
    input  payload_t in_data,
    output payload_t out_data
);

    generate
        if (depth == 0) begin : g_wire
            assign out_data = in_data;
        end else begin : g_stages
            payload_t stages [depth];

            always_ff @(posedge clock) begin
                if (reset) begin
                    for (int i = 0; i < depth; i++) begin
                        stages[i] <= '0;
                    end
                end else begin
                    stages[0] <= in_data;
                    // Shift toward the output end
                    for (int i = 1; i < depth; i++) begin
                        stages[i] <= stages[i-1];
                    end
                end
            end

            assign out_data = stages[depth-1];
        end
    endgenerate

endmodule

//--- dp_mem_top.sv
// Operand memory subsystem; write data must arrive one cycle after its address, ior and cancel
`timescale 1ns/10ps

module dp_mem_top (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       ior,
    input  logic                       cancel,
    input  dpm_map_pkg::addr_t         read_addr_a,
    input  dpm_map_pkg::addr_t         read_addr_b,
    input  dpm_map_pkg::addr_t         write_addr_a,
    input  dpm_map_pkg::addr_t         write_addr_b,
    input  dpm_map_pkg::word_t         write_data_a,
    input  dpm_map_pkg::word_t         write_data_b,
    input  dpm_io_pkg::io_word_array_t io_read_data_a,
    input  dpm_io_pkg::io_word_array_t io_read_data_b,
    output dpm_map_pkg::word_t         read_data_a,
    output dpm_map_pkg::word_t         read_data_b,
    output dpm_io_pkg::io_word_array_t io_write_data_a,
    output dpm_io_pkg::io_word_array_t io_write_data_b,
    output dpm_io_pkg::io_sel_t        io_wren_a,
    output dpm_io_pkg::io_sel_t        io_wren_b
);

    // I/O window flags
    logic read_is_io_a;
    logic read_is_io_b;
    logic write_is_io_a;
    logic write_is_io_b;

    io_predication io_predication_i (
        .read_addr_a   (read_addr_a),
        .read_addr_b   (read_addr_b),
        .write_addr_a  (write_addr_a),
        .write_addr_b  (write_addr_b),
        .read_is_io_a  (read_is_io_a),
        .read_is_io_b  (read_is_io_b),
        .write_is_io_a (write_is_io_a),
        .write_is_io_b (write_is_io_b)
    );

    datapath_memory datapath_memory_i (
        .clock           (clock),
        .reset           (reset),
        .ior             (ior),
        .cancel          (cancel),
        .read_addr_a     (read_addr_a),
        .read_addr_b     (read_addr_b),
        .write_addr_a    (write_addr_a),
        .write_addr_b    (write_addr_b),
        .read_is_io_a    (read_is_io_a),
        .read_is_io_b    (read_is_io_b),
        .write_is_io_a   (write_is_io_a),
        .write_is_io_b   (write_is_io_b),
        .write_data_a    (write_data_a),
        .write_data_b    (write_data_b),
        .io_read_data_a  (io_read_data_a),
        .io_read_data_b  (io_read_data_b),
        .io_write_data_a (io_write_data_a),
        .io_write_data_b (io_write_data_b),
        .io_wren_a       (io_wren_a),
        .io_wren_b       (io_wren_b),
        .read_data_a     (read_data_a),
        .read_data_b     (read_data_b)
    );

endmodule

//--- dpm_io_pkg.sv
// I/O window sits at the top of the address space and must not overlap any RAM write range
package dpm_io_pkg;

    // --------------------------------------------------
    // Port window
    localparam int io_port_count      = 4;
    localparam int io_port_base_addr  = 1020;
    localparam int io_port_addr_width = 2;

    // One write enable per port, at most one set at a time
    typedef logic [io_port_count-1:0] io_sel_t;

    // One data word per port
    typedef dpm_map_pkg::word_t [io_port_count-1:0] io_word_array_t;

endpackage

//--- dpm_map_pkg.sv
// Address map is fixed at elaboration; ranges assume bound >= base and RAM windows that are power-of-two aligned
package dpm_map_pkg;

    // --------------------------------------------------
    // Word and address widths
    localparam int word_width     = 32;
    localparam int addr_width     = 10;
    localparam int mem_addr_width = 8;

    // --------------------------------------------------
    // Memory ranges in the global address space
    localparam int mem_a_read_base_addr   = 0;
    localparam int mem_a_read_bound_addr  = 255;
    localparam int mem_a_write_base_addr  = 0;
    localparam int mem_a_write_bound_addr = 255;

    localparam int mem_b_read_base_addr   = 0;
    localparam int mem_b_read_bound_addr  = 255;
    localparam int mem_b_write_base_addr  = 0;
    localparam int mem_b_write_bound_addr = 255;

    // ALU write data lags its address by this many cycles
    localparam int write_retime_stages = 1;

    typedef logic [word_width-1:0]     word_t;
    typedef logic [addr_width-1:0]     addr_t;
    typedef logic [mem_addr_width-1:0] mem_addr_t;

    // Write address with its I/O flag, retimed as one unit
    typedef struct packed {
        addr_t addr;
        logic  is_io;
    } waddr_t;

endpackage

//--- io_predication.sv
// Purely combinational I/O window decode; flags are valid in the same cycle as the addresses
`timescale 1ns/10ps

module io_predication (
    input  dpm_map_pkg::addr_t read_addr_a,
    input  dpm_map_pkg::addr_t read_addr_b,
    input  dpm_map_pkg::addr_t write_addr_a,
    input  dpm_map_pkg::addr_t write_addr_b,
    output logic               read_is_io_a,
    output logic               read_is_io_b,
    output logic               write_is_io_a,
    output logic               write_is_io_b
);

    // --------------------------------------------------
    // Window test shared by all four addresses

    // Offset from the window base, negative when below it
    function automatic logic is_io_addr(input dpm_map_pkg::addr_t addr);
        int offset;
        offset = int'(addr) - dpm_io_pkg::io_port_base_addr;
        return (offset >= 0) && (offset < dpm_io_pkg::io_port_count);
    endfunction

    // --------------------------------------------------
    // Read side

    always_comb begin
        read_is_io_a = is_io_addr(read_addr_a);
        read_is_io_b = is_io_addr(read_addr_b);
    end

    // --------------------------------------------------
    // Write side
    // Flags travel with the write address through the retiming stage

    always_comb begin
        write_is_io_a = is_io_addr(write_addr_a);
        write_is_io_b = is_io_addr(write_addr_b);
    end

endmodule

//--- src.f
dpm_map_pkg.sv
dpm_io_pkg.sv
delay_line.sv
io_predication.sv
data_memory.sv
datapath_memory.sv
dp_mem_top.sv
tb_dp_mem_properties.sv
tb_dp_mem.sv

//--- tb_dp_mem.sv
// Expects RAM ranges 0..255 on both sides, I/O ports at 1020..1023 and one cycle of write retiming
`timescale 1ns/10ps

module tb_dp_mem;

    // --------------------------------------------------
    // Run length and address limits
    localparam int n_init       = 256;
    localparam int n_random     = 200;
    localparam int n_zero       = 4;
    localparam int n_alias      = 40;
    localparam int n_blocked    = 60;
    localparam int n_io         = 24;
    localparam int n_per_test   = 8;
    localparam int total_cycles = n_init + n_random + n_zero + n_alias + n_blocked + n_io
                                + 6 * n_per_test;
    localparam int cycle_limit  = total_cycles * 3 / 2 + 100;
    localparam int ram_words    = 1 << dpm_map_pkg::mem_addr_width;
    localparam int addr_max     = (1 << dpm_map_pkg::addr_width) - 1;
    localparam int port_bits    = dpm_io_pkg::io_port_addr_width;

    // Results due at the falling edge where cycle equals due
    typedef struct {
        int                         due;
        dpm_map_pkg::word_t         read_a;
        dpm_map_pkg::word_t         read_b;
        dpm_io_pkg::io_sel_t        wren_a;
        dpm_io_pkg::io_sel_t        wren_b;
        dpm_io_pkg::io_word_array_t io_a;
        dpm_io_pkg::io_word_array_t io_b;
    } expect_t;

    logic                       clock;
    logic                       reset;
    logic                       ior;
    logic                       cancel;
    dpm_map_pkg::addr_t         read_addr_a;
    dpm_map_pkg::addr_t         read_addr_b;
    dpm_map_pkg::addr_t         write_addr_a;
    dpm_map_pkg::addr_t         write_addr_b;
    dpm_map_pkg::word_t         write_data_a;
    dpm_map_pkg::word_t         write_data_b;
    dpm_io_pkg::io_word_array_t io_read_data_a;
    dpm_io_pkg::io_word_array_t io_read_data_b;
    dpm_map_pkg::word_t         read_data_a;
    dpm_map_pkg::word_t         read_data_b;
    dpm_io_pkg::io_word_array_t io_write_data_a;
    dpm_io_pkg::io_word_array_t io_write_data_b;
    dpm_io_pkg::io_sel_t        io_wren_a;
    dpm_io_pkg::io_sel_t        io_wren_b;

    // Reference state
    dpm_map_pkg::word_t         shadow_a [ram_words];
    dpm_map_pkg::word_t         shadow_b [ram_words];
    dpm_io_pkg::io_word_array_t io_reg_a;
    dpm_io_pkg::io_word_array_t io_reg_b;

    // Instruction issued on the previous step, whose data goes out on the next one
    logic                       pend_ok;
    dpm_map_pkg::addr_t         pend_wa;
    dpm_map_pkg::addr_t         pend_wb;
    dpm_map_pkg::word_t         pend_da;
    dpm_map_pkg::word_t         pend_db;

    expect_t                    expect_q [$];
    int                         cycle = 0;
    int                         checks = 0;
    int                         errors = 0;
    int                         test_start_errors = 0;

    dp_mem_top dut_i (
        .clock           (clock),
        .reset           (reset),
        .ior             (ior),
        .cancel          (cancel),
        .read_addr_a     (read_addr_a),
        .read_addr_b     (read_addr_b),
        .write_addr_a    (write_addr_a),
        .write_addr_b    (write_addr_b),
        .write_data_a    (write_data_a),
        .write_data_b    (write_data_b),
        .io_read_data_a  (io_read_data_a),
        .io_read_data_b  (io_read_data_b),
        .read_data_a     (read_data_a),
        .read_data_b     (read_data_b),
        .io_write_data_a (io_write_data_a),
        .io_write_data_b (io_write_data_b),
        .io_wren_a       (io_wren_a),
        .io_wren_b       (io_wren_b)
    );

    initial begin : clock_gen
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // --------------------------------------------------
    // Reference model

    function automatic dpm_map_pkg::word_t model_read(input logic side_b,
                                                      input dpm_map_pkg::addr_t addr,
                                                      input dpm_io_pkg::io_word_array_t io_in);
        dpm_map_pkg::mem_addr_t index;
        index = addr[dpm_map_pkg::mem_addr_width-1:0];
        if (addr == '0) begin
            return '0;
        end
        if (int'(addr) >= dpm_io_pkg::io_port_base_addr) begin
            return io_in[addr[port_bits-1:0]];
        end
        // Addresses above the RAM alias onto its low bits
        return side_b ? shadow_b[index] : shadow_a[index];
    endfunction

    function automatic dpm_io_pkg::io_sel_t apply_write(input logic side_b,
                                                        input dpm_map_pkg::addr_t addr,
                                                        input dpm_map_pkg::word_t data);
        dpm_io_pkg::io_sel_t    sel;
        logic [port_bits-1:0]   port;
        dpm_map_pkg::mem_addr_t index;
        int                     base;
        int                     bound;
        sel   = '0;
        port  = addr[port_bits-1:0];
        index = addr[dpm_map_pkg::mem_addr_width-1:0];
        base  = side_b ? dpm_map_pkg::mem_b_write_base_addr : dpm_map_pkg::mem_a_write_base_addr;
        bound = side_b ? dpm_map_pkg::mem_b_write_bound_addr : dpm_map_pkg::mem_a_write_bound_addr;
        if (int'(addr) >= dpm_io_pkg::io_port_base_addr) begin
            sel[port] = 1'b1;
            if (side_b) begin
                io_reg_b[port] = data;
            end else begin
                io_reg_a[port] = data;
            end
        end else if (int'(addr) >= base && int'(addr) <= bound) begin
            if (side_b) begin
                shadow_b[index] = data;
            end else begin
                shadow_a[index] = data;
            end
        end
        return sel;
    endfunction

    function automatic dpm_map_pkg::addr_t random_addr(input int lo, input int hi);
        return dpm_map_pkg::addr_t'(lo + int'($urandom % (hi - lo + 1)));
    endfunction

    // --------------------------------------------------
    // Compare tasks

    task automatic check_word(input string what, input dpm_map_pkg::word_t got,
                              input dpm_map_pkg::word_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_sel(input string what, input dpm_io_pkg::io_sel_t got,
                             input dpm_io_pkg::io_sel_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    task automatic check_ports(input string what, input dpm_io_pkg::io_word_array_t got,
                               input dpm_io_pkg::io_word_array_t want);
        int p;
        for (p = 0; p < dpm_io_pkg::io_port_count; p++) begin
            check_word($sformatf("%s[%0d]", what, p), got[p[port_bits-1:0]],
                       want[p[port_bits-1:0]]);
        end
    endtask

    initial begin : compare
        expect_t expected;
        forever begin
            @(negedge clock);
            while (expect_q.size() != 0 && expect_q[0].due == cycle) begin
                expected = expect_q.pop_front();
                check_word("read_data_a", read_data_a, expected.read_a);
                check_word("read_data_b", read_data_b, expected.read_b);
                check_sel("io_wren_a", io_wren_a, expected.wren_a);
                check_sel("io_wren_b", io_wren_b, expected.wren_b);
                check_ports("io_write_data_a", io_write_data_a, expected.io_a);
                check_ports("io_write_data_b", io_write_data_b, expected.io_b);
            end
        end
    end

    // --------------------------------------------------
    // Stimulus

    // One instruction per falling edge; its data follows on the next step
    task automatic step(input dpm_map_pkg::addr_t ra, input dpm_map_pkg::addr_t rb,
                        input dpm_map_pkg::addr_t wa, input dpm_map_pkg::addr_t wb,
                        input logic st_ior, input logic st_cancel);
        expect_t                    expected;
        dpm_io_pkg::io_word_array_t io_in_a;
        dpm_io_pkg::io_word_array_t io_in_b;
        int                         p;
        @(negedge clock);
        for (p = 0; p < dpm_io_pkg::io_port_count; p++) begin
            io_in_a[p[port_bits-1:0]] = dpm_map_pkg::word_t'($urandom);
            io_in_b[p[port_bits-1:0]] = dpm_map_pkg::word_t'($urandom);
        end
        expected.due    = cycle + 1;
        // Reads see the RAM before the write that commits at the same edge
        expected.read_a = model_read(1'b0, ra, io_in_a);
        expected.read_b = model_read(1'b1, rb, io_in_b);
        expected.wren_a = pend_ok ? apply_write(1'b0, pend_wa, pend_da) : '0;
        expected.wren_b = pend_ok ? apply_write(1'b1, pend_wb, pend_db) : '0;
        expected.io_a   = io_reg_a;
        expected.io_b   = io_reg_b;
        expect_q.push_back(expected);

        read_addr_a    = ra;
        read_addr_b    = rb;
        write_addr_a   = wa;
        write_addr_b   = wb;
        ior            = st_ior;
        cancel         = st_cancel;
        write_data_a   = pend_da;
        write_data_b   = pend_db;
        io_read_data_a = io_in_a;
        io_read_data_b = io_in_b;

        pend_ok = st_ior & ~st_cancel;
        pend_wa = wa;
        pend_wb = wb;
        pend_da = dpm_map_pkg::word_t'($urandom);
        pend_db = dpm_map_pkg::word_t'($urandom);
    endtask

    // Read addresses stay at ra and rb while reset is held
    task automatic apply_reset(input dpm_map_pkg::addr_t ra, input dpm_map_pkg::addr_t rb);
        reset          = 1'b1;
        ior            = 1'b0;
        cancel         = 1'b0;
        read_addr_a    = ra;
        read_addr_b    = rb;
        write_addr_a   = '0;
        write_addr_b   = '0;
        write_data_a   = '0;
        write_data_b   = '0;
        io_read_data_a = '0;
        io_read_data_b = '0;
        repeat (4) @(negedge clock);
        reset    = 1'b0;
        pend_ok  = 1'b0;
        pend_da  = '0;
        pend_db  = '0;
        io_reg_a = '0;
        io_reg_b = '0;
        check_word("read_data_a after reset", read_data_a, '0);
        check_word("read_data_b after reset", read_data_b, '0);
        check_sel("io_wren_a after reset", io_wren_a, '0);
        check_sel("io_wren_b after reset", io_wren_b, '0);
        check_ports("io_write_data_a after reset", io_write_data_a, '0);
        check_ports("io_write_data_b after reset", io_write_data_b, '0);
    endtask

    // Commit the last instruction, wait for its results, then report
    task automatic end_test(input int number, input string name);
        step('0, '0, '0, '0, 1'b0, 1'b0);
        while (expect_q.size() != 0) begin
            @(posedge clock);
        end
        $display("Test %0d %s: %0d errors", number, name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    initial begin : stimulus
        dpm_map_pkg::addr_t hist_a1;
        dpm_map_pkg::addr_t hist_a2;
        dpm_map_pkg::addr_t hist_b1;
        dpm_map_pkg::addr_t hist_b2;
        dpm_map_pkg::addr_t wa;
        dpm_map_pkg::addr_t wb;
        int                 i;
        int                 mode;
        void'($urandom(17723));
        apply_reset('0, '0);

        // Fill both RAMs, then random traffic with reads during writes
        for (i = 0; i < n_init; i++) begin
            step('0, '0, dpm_map_pkg::addr_t'(i), dpm_map_pkg::addr_t'(i), 1'b1, 1'b0);
        end
        step('0, '0, '0, '0, 1'b0, 1'b0);
        for (i = 0; i < n_random; i++) begin
            step(random_addr(1, ram_words - 1), random_addr(1, ram_words - 1),
                 random_addr(0, ram_words - 1), random_addr(0, ram_words - 1), 1'b1, 1'b0);
        end
        end_test(1, "random write and read-back");

        // Address 0 is written but reads as zero; 256 reaches the stored word
        step('0, '0, '0, '0, 1'b1, 1'b0);
        step('0, '0, '0, '0, 1'b0, 1'b0);
        step('0, '0, '0, '0, 1'b0, 1'b0);
        step(dpm_map_pkg::addr_t'(ram_words), dpm_map_pkg::addr_t'(ram_words),
             '0, '0, 1'b0, 1'b0);
        end_test(2, "zero register");

        // Each dropped write is read back through its alias two steps later
        hist_a1 = dpm_map_pkg::addr_t'(ram_words);
        hist_a2 = hist_a1;
        hist_b1 = hist_a1;
        hist_b2 = hist_a1;
        for (i = 0; i < n_alias; i++) begin
            wa = random_addr(ram_words, dpm_io_pkg::io_port_base_addr - 1);
            wb = random_addr(ram_words, dpm_io_pkg::io_port_base_addr - 1);
            step(hist_a2, hist_b2, wa, wb, 1'b1, 1'b0);
            hist_a2 = hist_a1;
            hist_a1 = wa;
            hist_b2 = hist_b1;
            hist_b1 = wb;
        end
        end_test(3, "out-of-range writes");

        for (i = 0; i < n_blocked; i++) begin
            mode = int'($urandom % 3);
            step(random_addr(1, addr_max), random_addr(1, addr_max),
                 random_addr(0, addr_max), random_addr(0, addr_max), mode == 1, mode != 0);
        end
        end_test(4, "blocked writes");

        // Writes on every other step keep the strobes apart
        for (i = 0; i < n_io; i++) begin
            step(random_addr(dpm_io_pkg::io_port_base_addr, addr_max),
                 random_addr(dpm_io_pkg::io_port_base_addr, addr_max),
                 random_addr(dpm_io_pkg::io_port_base_addr, addr_max),
                 random_addr(dpm_io_pkg::io_port_base_addr, addr_max), i % 2 == 0, 1'b0);
        end
        end_test(5, "I/O ports");

        // Reset lands on a pending I/O commit while RAM reads stay active
        step(dpm_map_pkg::addr_t'(1), dpm_map_pkg::addr_t'(1),
             dpm_map_pkg::addr_t'(addr_max), dpm_map_pkg::addr_t'(addr_max), 1'b1, 1'b0);
        @(negedge clock);
        apply_reset(dpm_map_pkg::addr_t'(1), dpm_map_pkg::addr_t'(1));
        end_test(6, "reset");

        $display("Tests: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycle < cycle_limit) begin
            @(posedge clock);
            cycle = cycle + 1;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- tb_dp_mem_properties.sv
// Bound into every data_memory instance; checks the port strobes and the disabled read path
`timescale 1ns/10ps

module tb_dp_mem_properties (
    input logic                clock,
    input logic                reset,
    input logic                read_enable,
    input dpm_io_pkg::io_sel_t io_wren,
    input dpm_map_pkg::word_t  read_data
);

    // At most one port strobes per commit
    io_wren_onehot: assert property (
        @(posedge clock) disable iff (reset) $onehot0(io_wren)
    ) else $error("io_wren has more than one bit set");

    io_wren_clear_after_reset: assert property (
        @(posedge clock) reset |=> (io_wren == '0)
    ) else $error("io_wren is not zero in the cycle after reset");

    // --------------------------------------------------
    // Address 0 and other disabled reads give zero
    read_zero_when_disabled: assert property (
        @(posedge clock) disable iff (reset) !read_enable |=> (read_data == '0)
    ) else $error("read_data is not zero after a read with read_enable low");

endmodule

bind data_memory tb_dp_mem_properties props_i (
    .clock       (clock),
    .reset       (reset),
    .read_enable (read_enable),
    .io_wren     (io_wren),
    .read_data   (read_data)
);
